/* src.f */
+incdir+verilog
verilog/ste_audio_pkg.sv
verilog/audio_ctrl_regs.sv
verilog/audio_mixer.sv
verilog/sigma_delta_dac.sv
verilog/ste_audio_top.sv
test/ste_audio_assertions.sv
test/tb_ste_audio.sv

/* test/ste_audio_assertions.sv */
//********************
// ste audio assertions
// axi response and reset checks on the top
//********************

`timescale 1ns/1ns

module ste_audio_assertions (
	input logic        clk_32,
	input logic        xsint,
	input logic        bvalid,
	input logic        bready,
	input logic [1:0]  bresp,
	input logic        rvalid,
	input logic        rready,
	input logic [1:0]  rresp,
	input logic [31:0] rdata,
	input logic        audio_l,
	input logic        audio_r
);

int unsigned fail_count = 0;  // failed assertions so far

// responses hold until taken
b_hold: assert property (@(posedge clk_32) disable iff (!xsint)
	bvalid && !bready |=> bvalid)
	else begin
		fail_count++;
		$error("bvalid dropped before bready");
	end

r_hold: assert property (@(posedge clk_32) disable iff (!xsint)
	rvalid && !rready |=> rvalid && $stable(rdata))
	else begin
		fail_count++;
		$error("rvalid or rdata changed before rready");
	end

resp_okay: assert property (@(posedge clk_32) disable iff (!xsint)
	(bvalid |-> bresp == 2'b00) and (rvalid |-> rresp == 2'b00))
	else begin
		fail_count++;
		$error("response code is not OKAY");
	end

// bitstreams quiet in reset
reset_quiet: assert property (@(posedge clk_32) !xsint |-> !audio_l && !audio_r)
	else begin
		fail_count++;
		$error("audio output high during reset");
	end

endmodule

/* test/ste_audio_cases.txt */
# psg_stereo ste_enable a b c dma_left dma_right expected_ones_left expected_ones_right
# decimal values, ones counted over 32768 cycles
0 1 0 0 0 128 128 8200 8200
0 1 100 100 100 128 128 13004 13004
0 1 200 200 112 128 128 16384 16384
1 1 200 50 20 128 128 12203 9321
1 1 200 50 20 192 64 16315 5273
1 0 200 50 20 192 64 12203 9321
0 1 255 255 255 255 0 28594 12275
0 0 255 255 255 255 0 20435 20435

/* test/tb_ste_audio.sv */
//********************
// ste audio testbench
// axi register access and bitstream density cases
//********************

`timescale 1ns/1ns
`include "ste_audio_consts.svh"

module tb_ste_audio;

typedef struct packed {
	ste_audio_pkg::audio_ctrl_t ctrl;
	ste_audio_pkg::psg_levels_t psg;
	ste_audio_pkg::dma_sample_t dma;
	logic [15:0]                exp_l;  // ones per 32768 cycles
	logic [15:0]                exp_r;
} audio_case_t;

logic                       clk_32;
logic                       xsint;
logic [`AXI_ADDR_W-1:0]     awaddr;
logic                       awvalid;
logic                       awready;
logic [`AXI_DATA_W-1:0]     wdata;
logic [`AXI_DATA_W/8-1:0]   wstrb;
logic                       wvalid;
logic                       wready;
logic [1:0]                 bresp;
logic                       bvalid;
logic                       bready;
logic [`AXI_ADDR_W-1:0]     araddr;
logic                       arvalid;
logic                       arready;
logic [`AXI_DATA_W-1:0]     rdata;
logic [1:0]                 rresp;
logic                       rvalid;
logic                       rready;
ste_audio_pkg::psg_levels_t psg;
ste_audio_pkg::dma_sample_t dma;
logic                       audio_l;
logic                       audio_r;

int          errors;
int          tests;
int          passed;
bit          cases_loaded;
audio_case_t cases[$];

ste_audio_top u_ste_audio_top (.*);

bind ste_audio_top ste_audio_assertions u_ste_audio_assertions (
	.clk_32  (clk_32),
	.xsint   (xsint),
	.bvalid  (bvalid),
	.bready  (bready),
	.bresp   (bresp),
	.rvalid  (rvalid),
	.rready  (rready),
	.rresp   (rresp),
	.rdata   (rdata),
	.audio_l (audio_l),
	.audio_r (audio_r)
);

initial begin
	clk_32 = 1'b0;
	forever #10 clk_32 = ~clk_32;  // 50 MHz
end

task automatic next_cycle();
	@(posedge clk_32);
	#2;
endtask

task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input logic [3:0] strb);
	int cnt;
	int gap;
	cnt = 0;
	gap = $urandom_range(3, 0);
	next_cycle();
	awaddr  = addr;
	wdata   = data;
	wstrb   = strb;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	while (!(awready && wready) && cnt < 32) begin
		next_cycle();
		cnt++;
	end
	next_cycle();  // handshake edge
	awvalid = 1'b0;
	wvalid  = 1'b0;
	repeat (gap) next_cycle();
	bready = 1'b1;
	while (!bvalid && cnt < 32) begin
		next_cycle();
		cnt++;
	end
	next_cycle();
	bready = 1'b0;
	if (cnt >= 32) begin
		$display("write to address %0h never completed its handshake", addr);
		errors++;
	end
endtask

task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
	int cnt;
	int gap;
	cnt = 0;
	gap = $urandom_range(3, 0);
	next_cycle();
	araddr  = addr;
	arvalid = 1'b1;
	while (!arready && cnt < 32) begin
		next_cycle();
		cnt++;
	end
	next_cycle();
	arvalid = 1'b0;
	repeat (gap) next_cycle();
	rready = 1'b1;
	while (!rvalid && cnt < 32) begin
		next_cycle();
		cnt++;
	end
	data = rdata;
	next_cycle();
	rready = 1'b0;
	if (cnt >= 32) begin
		$display("read of address %0h never completed its handshake", addr);
		errors++;
	end
endtask

task automatic count_ones(output int ones_l, output int ones_r);
	ones_l = 0;
	ones_r = 0;
	repeat (32768) begin
		next_cycle();
		ones_l += audio_l;
		ones_r += audio_r;
	end
endtask

task automatic end_test(input string name, input int errs_before);
	tests++;
	if (errors == errs_before) begin
		passed++;
		$display("test %s passed", name);
	end else begin
		$display("test %s failed", name);
	end
endtask

initial begin
	wait (cases_loaded);
	#((cases.size() * 32800 + 2000) * 20);
	$display("watchdog expired before the tests finished");
	$display("ERRORS FOUND");
	$finish;
end

initial begin
	int          fd;
	int          n;
	int          f[9];
	int          errs_before;
	int          ones_l;
	int          ones_r;
	int          diff_l;
	int          diff_r;
	string       line;
	logic [31:0] rd;
	audio_case_t tc;
	xsint   = 1'b0;
	awaddr  = '0;
	awvalid = 1'b0;
	wdata   = '0;
	wstrb   = '0;
	wvalid  = 1'b0;
	bready  = 1'b0;
	araddr  = '0;
	arvalid = 1'b0;
	rready  = 1'b0;
	psg     = '0;
	dma     = '{left: 8'd128, right: 8'd128};  // dma silence
	errors  = 0;
	tests   = 0;
	passed  = 0;
	void'($urandom(32'hd957f230));

	fd = $fopen("test/ste_audio_cases.txt", "r");
	if (fd == 0) begin
		$display("could not open the case file test/ste_audio_cases.txt");
		errors++;
	end else begin
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
				if (n == 9) begin
					tc.ctrl = '{psg_stereo: f[0][0], ste_enable: f[1][0]};
					tc.psg  = '{a: f[2][7:0], b: f[3][7:0], c: f[4][7:0]};
					tc.dma  = '{left: f[5][7:0], right: f[6][7:0]};
					tc.exp_l = f[7][15:0];
					tc.exp_r = f[8][15:0];
					cases.push_back(tc);
				end
			end
		end
		$fclose(fd);
		if (cases.size() == 0) begin
			$display("the case file held no cases");
			errors++;
		end
	end
	cases_loaded = 1'b1;

	// reset defaults, outputs quiet while xsint is low
	errs_before = errors;
	repeat (3) begin
		next_cycle();
		if (audio_l !== 1'b0 || audio_r !== 1'b0) begin
			$display("ERR %0t: audio output high during reset", $time);
			errors++;
		end
	end
	xsint = 1'b1;
	axi_read(`CTRL_ADDR, rd);
	if (rd !== 32'h2) begin
		$display("ERR %0t: control after reset %0h, expected 2", $time, rd);
		errors++;
	end
	end_test("reset_defaults", errs_before);

	// register write and read back
	errs_before = errors;
	for (int i = 0; i < 4; i++) begin
		axi_write(`CTRL_ADDR, i, 4'h1);
		axi_read(`CTRL_ADDR, rd);
		if (rd !== 32'(i)) begin
			$display("ERR %0t: control read %0h, expected %0h", $time, rd, i);
			errors++;
		end
	end
	axi_write(`CTRL_ADDR, 32'h1, 4'h0);  // lane 0 not strobed
	axi_write(4'h8, 32'h0, 4'hf);        // unmapped
	axi_read(`CTRL_ADDR, rd);
	if (rd !== 32'h3) begin
		$display("ERR %0t: control changed by ignored writes, read %0h", $time, rd);
		errors++;
	end
	axi_read(4'h4, rd);
	if (rd !== 32'h0) begin
		$display("ERR %0t: unmapped address read %0h, expected 0", $time, rd);
		errors++;
	end
	end_test("register_access", errs_before);

	foreach (cases[i]) begin
		tc = cases[i];
		errs_before = errors;
		axi_write(`CTRL_ADDR, {30'b0, tc.ctrl.ste_enable, tc.ctrl.psg_stereo}, 4'h1);
		next_cycle();
		psg = tc.psg;
		dma = tc.dma;
		repeat (4) @(posedge clk_32);  // mixer and dac settle
		count_ones(ones_l, ones_r);
		diff_l = ones_l - int'(tc.exp_l);
		diff_r = ones_r - int'(tc.exp_r);
		if (diff_l > 1 || diff_l < -1) begin
			$display("ERR %0t: case %0d left ones %0d, expected %0d",
				$time, i + 1, ones_l, tc.exp_l);
			errors++;
		end
		if (diff_r > 1 || diff_r < -1) begin
			$display("ERR %0t: case %0d right ones %0d, expected %0d",
				$time, i + 1, ones_r, tc.exp_r);
			errors++;
		end
		end_test($sformatf("case_%0d", i + 1), errs_before);
	end

	errors += u_ste_audio_top.u_ste_audio_assertions.fail_count;
	$display("tests %0d, passed %0d, failed %0d, errors %0d",
		tests, passed, tests - passed, errors);
	if (errors == 0) begin
		$display("NO ERRORS");
	end else begin
		$display("ERRORS FOUND");
	end
	$finish;
end

endmodule

/* verilog/audio_ctrl_regs.sv */
//********************
// audio control registers
// axi4-lite slave holding the mixer control bits
//********************

`timescale 1ns/1ns
`include "ste_audio_consts.svh"

module audio_ctrl_regs (
	input  logic                       clk_32,
	input  logic                       xsint,
	input  logic [`AXI_ADDR_W-1:0]     awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [`AXI_DATA_W-1:0]     wdata,
	input  logic [`AXI_DATA_W/8-1:0]   wstrb,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  logic [`AXI_ADDR_W-1:0]     araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [`AXI_DATA_W-1:0]     rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready,
	output ste_audio_pkg::audio_ctrl_t ctrl
);

localparam logic [1:0] RESP_OKAY = 2'b00;

logic wr_take;  // address and data both present, nothing pending
logic wr_hs;
logic rd_hs;
logic wr_sel;
logic rd_sel;

assign wr_take = awvalid & wvalid & ~awready & ~bvalid;
assign wr_hs   = awready & awvalid & wready & wvalid;
assign rd_hs   = arready & arvalid;

// only one register in the map
assign wr_sel = (awaddr == `AXI_ADDR_W'(`CTRL_ADDR));
assign rd_sel = (araddr == `AXI_ADDR_W'(`CTRL_ADDR));

assign bresp = RESP_OKAY;
assign rresp = RESP_OKAY;

// write address, data and response
always_ff @(posedge clk_32 or negedge xsint) begin
	if (!xsint) begin
		awready <= 1'b0;
		wready  <= 1'b0;
		bvalid  <= 1'b0;
	end else begin
		awready <= wr_take;  // single cycle pulse
		wready  <= wr_take;
		if (wr_hs)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;  // hold until taken
	end
end

// control bits, byte lane 0 only
always_ff @(posedge clk_32 or negedge xsint) begin
	if (!xsint) begin
		ctrl.psg_stereo <= 1'b0;
		ctrl.ste_enable <= 1'b1;  // ste sound on after reset
	end else if (wr_hs && wr_sel && wstrb[0]) begin
		ctrl.psg_stereo <= wdata[0];
		ctrl.ste_enable <= wdata[1];
	end
end

// read address and response
always_ff @(posedge clk_32 or negedge xsint) begin
	if (!xsint) begin
		arready <= 1'b0;
		rvalid  <= 1'b0;
	end else begin
		arready <= arvalid & ~arready & ~rvalid;
		if (rd_hs)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end
end

// read data captured with the address
always_ff @(posedge clk_32) begin
	if (rd_hs)
		rdata <= rd_sel ? `AXI_DATA_W'({ctrl.ste_enable, ctrl.psg_stereo}) : '0;
end

endmodule

/* verilog/audio_mixer.sv */
//********************
// audio mixer
// psg and dma sound summed to a 15 bit stereo mix
//********************

`timescale 1ns/1ns
`include "ste_audio_consts.svh"

module audio_mixer (
	input  logic                       clk_32,
	input  logic                       xsint,
	input  ste_audio_pkg::audio_ctrl_t ctrl,
	input  ste_audio_pkg::psg_levels_t psg,
	input  ste_audio_pkg::dma_sample_t dma,
	output ste_audio_pkg::audio_mix_t  mix
);

// both sources expanded to 14 bits, sign extended, then added
function automatic logic [`MIX_W-1:0] scale_mix(
	input logic [`PSG_SUM_W-1:0] psg_s,
	input logic [`DMA_W-1:0]     dma_s
);
	return {psg_s[`PSG_SUM_W-1], psg_s, psg_s[`PSG_SUM_W-1 -: 4]} +
	       {dma_s[`DMA_W-1], dma_s, dma_s[`DMA_W-1 -: 6]};
endfunction

logic [`PSG_SUM_W-1:0] sum_ab;
logic [`PSG_SUM_W-1:0] sum_cb;
logic [`PSG_SUM_W-1:0] sum_abc;
logic [`PSG_SUM_W-1:0] psg_l_s;
logic [`PSG_SUM_W-1:0] psg_r_s;
logic [`DMA_W-1:0]     dma_l_s;
logic [`DMA_W-1:0]     dma_r_s;

assign sum_ab  = `PSG_SUM_W'(psg.a) + `PSG_SUM_W'(psg.b);
assign sum_cb  = `PSG_SUM_W'(psg.c) + `PSG_SUM_W'(psg.b);
assign sum_abc = sum_ab + `PSG_SUM_W'(psg.c);

// mono puts all three channels on both sides
assign psg_l_s = (ctrl.psg_stereo ? sum_ab : sum_abc) - `PSG_SUM_W'(`PSG_OFFSET);
assign psg_r_s = (ctrl.psg_stereo ? sum_cb : sum_abc) - `PSG_SUM_W'(`PSG_OFFSET);

assign dma_l_s = ctrl.ste_enable ? dma.left - `DMA_W'(`DMA_OFFSET) : '0;
assign dma_r_s = ctrl.ste_enable ? dma.right - `DMA_W'(`DMA_OFFSET) : '0;

always_ff @(posedge clk_32 or negedge xsint) begin
	if (!xsint) begin
		mix <= '0;
	end else begin
		mix.left  <= scale_mix(psg_l_s, dma_l_s);
		mix.right <= scale_mix(psg_r_s, dma_r_s);
	end
end

endmodule

/* verilog/sigma_delta_dac.sv */
//********************
// sigma-delta dac
// first order modulator per channel, 1 bit out
//********************

`timescale 1ns/1ns
`include "ste_audio_consts.svh"

module sigma_delta_dac (
	input  logic                      clk_32,
	input  logic                      xsint,
	input  ste_audio_pkg::audio_mix_t mix,
	output logic                      audio_l,
	output logic                      audio_r
);

logic [1:0][`MIX_W-1:0] level;  // offset binary, 0 is left
logic [1:0][`MIX_W-1:0] acc;
logic [1:0]             carry;

// flipping the sign bit turns two's complement into offset binary
assign level[0] = {~mix.left[`MIX_W-1], mix.left[`MIX_W-2:0]};
assign level[1] = {~mix.right[`MIX_W-1], mix.right[`MIX_W-2:0]};

// carry density tracks level / 2^MIX_W
always_ff @(posedge clk_32 or negedge xsint) begin
	if (!xsint) begin
		acc   <= '0;
		carry <= '0;
	end else begin
		for (int i = 0; i < 2; i++)
			{carry[i], acc[i]} <= {1'b0, acc[i]} + {1'b0, level[i]};
	end
end

assign audio_l = carry[0];
assign audio_r = carry[1];

endmodule

/* verilog/ste_audio_consts.svh */
//********************
// ste audio constants
// widths, register map and midpoints of the audio path
//********************

`ifndef STE_AUDIO_CONSTS_SVH
`define STE_AUDIO_CONSTS_SVH

`define PSG_W       8     // one psg channel level
`define PSG_SUM_W   10    // a+b+c fits here
`define DMA_W       8     // one dma sound sample
`define MIX_W       15    // mixed channel, dac accumulator

`define AXI_ADDR_W  4
`define AXI_DATA_W  32
`define CTRL_ADDR   0     // control register byte address

`define PSG_OFFSET  512   // midpoint of a psg sum
`define DMA_OFFSET  128   // midpoint of a dma sample

`endif

/* verilog/ste_audio_pkg.sv */
//********************
// ste audio types
// struct types shared along the audio path
//********************

`include "ste_audio_consts.svh"

package ste_audio_pkg;

	typedef struct packed {
		logic [`PSG_W-1:0] a;
		logic [`PSG_W-1:0] b;
		logic [`PSG_W-1:0] c;
	} psg_levels_t;

	typedef struct packed {
		logic [`DMA_W-1:0] left;
		logic [`DMA_W-1:0] right;
	} dma_sample_t;

	// two's complement per side
	typedef struct packed {
		logic signed [`MIX_W-1:0] left;
		logic signed [`MIX_W-1:0] right;
	} audio_mix_t;

	typedef struct packed {
		logic psg_stereo;  // a left, c right, b both
		logic ste_enable;  // add dma sound
	} audio_ctrl_t;

endpackage

/* verilog/ste_audio_top.sv */
//********************
// ste audio top
// control registers, mixer and bitstream dac
//********************

`timescale 1ns/1ns
`include "ste_audio_consts.svh"

module ste_audio_top (
	input  logic                       clk_32,
	input  logic                       xsint,
	input  logic [`AXI_ADDR_W-1:0]     awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [`AXI_DATA_W-1:0]     wdata,
	input  logic [`AXI_DATA_W/8-1:0]   wstrb,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  logic [`AXI_ADDR_W-1:0]     araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [`AXI_DATA_W-1:0]     rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready,
	input  ste_audio_pkg::psg_levels_t psg,
	input  ste_audio_pkg::dma_sample_t dma,
	output logic                       audio_l,
	output logic                       audio_r
);

ste_audio_pkg::audio_ctrl_t ctrl;
ste_audio_pkg::audio_mix_t  mix;

audio_ctrl_regs u_audio_ctrl_regs (
	.clk_32  (clk_32),
	.xsint   (xsint),
	.awaddr  (awaddr),
	.awvalid (awvalid),
	.awready (awready),
	.wdata   (wdata),
	.wstrb   (wstrb),
	.wvalid  (wvalid),
	.wready  (wready),
	.bresp   (bresp),
	.bvalid  (bvalid),
	.bready  (bready),
	.araddr  (araddr),
	.arvalid (arvalid),
	.arready (arready),
	.rdata   (rdata),
	.rresp   (rresp),
	.rvalid  (rvalid),
	.rready  (rready),
	.ctrl    (ctrl)
);

audio_mixer u_audio_mixer (
	.clk_32 (clk_32),
	.xsint  (xsint),
	.ctrl   (ctrl),
	.psg    (psg),
	.dma    (dma),
	.mix    (mix)
);

sigma_delta_dac u_sigma_delta_dac (
	.clk_32  (clk_32),
	.xsint   (xsint),
	.mix     (mix),
	.audio_l (audio_l),  // left bitstream
	.audio_r (audio_r)
);

endmodule
